/* verilog/spi_pkg.sv */
/*
 * Shared definitions for the SPI master controller.
 * Holds the data widths, the register map, the configuration reset values
 * and the engine state type. Modules import it inside their body.
 */

package spi_pkg;

    // sizes --------------------
    localparam int SPI_DATA_WIDTH = 8;
    localparam int FIFO_DEPTH     = 16;
    localparam int SLAVE_NUM      = 2;   // one chip select per slave.

    typedef logic [SPI_DATA_WIDTH-1:0] spi_data_t;
    typedef logic [SPI_DATA_WIDTH:0]   spi_tx_word_t;   // bit 8 closes the frame.
    typedef logic [2:0]                reg_addr_t;
    typedef logic [31:0]               reg_data_t;
    typedef logic [7:0]                clk_div_t;       // half period is value + 1.
    typedef logic [7:0]                wait_time_t;

    // register map -------------
    localparam reg_addr_t ADDR_CONTROL   = 3'd0;
    localparam reg_addr_t ADDR_STATUS    = 3'd1;
    localparam reg_addr_t ADDR_CLK_DIV   = 3'd2;
    localparam reg_addr_t ADDR_WAIT_TIME = 3'd3;
    localparam reg_addr_t ADDR_SLAVE_SEL = 3'd4;
    localparam reg_addr_t ADDR_TX_DATA   = 3'd5;
    localparam reg_addr_t ADDR_RX_DATA   = 3'd6;
    localparam reg_addr_t ADDR_PARAM     = 3'd7;

    // reset values.
    localparam reg_data_t                    CONTROL_RESET   = '0;
    localparam clk_div_t                     CLK_DIV_RESET   = 8'd1;
    localparam wait_time_t                   WAIT_TIME_RESET = 8'd2;
    localparam logic [$clog2(SLAVE_NUM)-1:0] SLAVE_SEL_RESET = '0;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        SHIFT,
        HOLD,
        GAP
    } engine_state_t;

endpackage

/* verilog/spi_fifo.sv */
/*
 * Synchronous first-word-fall-through FIFO with valid/ready on both sides.
 * A pushed word shows at the output on the next cycle. Used for the
 * TX words and the RX bytes. flush_i empties it in one cycle.
 */
`timescale 1ns/1ns

module spi_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             flush_i,
    input  logic             in_valid_i,
    input  logic [WIDTH-1:0] in_data_i,
    output logic             in_ready_o,
    output logic             out_valid_o,
    output logic [WIDTH-1:0] out_data_o,
    input  logic             out_ready_i
);
    localparam int PTR_W = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    assign in_ready_o  = (count != (PTR_W + 1)'(DEPTH));
    assign out_valid_o = (count != '0);
    assign out_data_o  = mem[rd_ptr];   // fall through.
    assign push        = in_valid_i && in_ready_o;
    assign pop         = out_valid_o && out_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= in_data_i;
        end
    end

    a_count_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        count <= (PTR_W + 1)'(DEPTH));
    // consumers must only pop a word they can see.
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_ready_i |-> out_valid_o)
        else $error("pop while empty");

endmodule

/* verilog/spi_reg_file.sv */
/*
 * Register port of the SPI controller.
 * Decodes host writes and reads, holds the configuration, turns TX data
 * writes into FIFO pushes and RX data reads into pops. Read data comes
 * back registered, one cycle after the read strobe.
 */
`timescale 1ns/1ns

module spi_reg_file (
    input  logic                                  clk_i,
    input  logic                                  rst_n_i,
    input  spi_pkg::reg_addr_t                    reg_addr_i,
    input  logic                                  reg_wr_i,
    input  spi_pkg::reg_data_t                    reg_wdata_i,
    input  logic                                  reg_rd_i,
    input  logic                                  tx_ready_i,
    input  logic                                  tx_empty_i,
    input  logic                                  rx_valid_i,
    input  logic                                  rx_full_i,
    input  spi_pkg::spi_data_t                    rx_byte_i,
    input  logic                                  busy_i,
    output spi_pkg::reg_data_t                    reg_rdata_o,
    output logic                                  tx_push_o,
    output spi_pkg::spi_tx_word_t                 tx_word_o,
    output logic                                  rx_pop_o,
    output logic                                  cpol_o,
    output logic                                  cpha_o,
    output spi_pkg::clk_div_t                     clk_div_o,
    output spi_pkg::wait_time_t                   wait_time_o,
    output logic [$clog2(spi_pkg::SLAVE_NUM)-1:0] slave_sel_o,
    output logic                                  soft_rst_o
);
    import spi_pkg::*;

    reg_data_t status_word;
    reg_data_t param_word;
    reg_data_t rd_mux;

    assign tx_push_o = reg_wr_i && (reg_addr_i == ADDR_TX_DATA);
    assign tx_word_o = reg_wdata_i[SPI_DATA_WIDTH:0];
    assign rx_pop_o  = reg_rd_i && (reg_addr_i == ADDR_RX_DATA) && rx_valid_i;

    // live status, read-only.
    assign status_word = reg_data_t'({busy_i, ~tx_ready_i, rx_full_i, tx_empty_i, ~rx_valid_i});
    assign param_word  = reg_data_t'({8'(FIFO_DEPTH), 8'(SPI_DATA_WIDTH)});

    // configuration --------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            {cpha_o, cpol_o, soft_rst_o} <= CONTROL_RESET[2:0];
            clk_div_o                    <= CLK_DIV_RESET;
            wait_time_o                  <= WAIT_TIME_RESET;
            slave_sel_o                  <= SLAVE_SEL_RESET;
        end else begin
            soft_rst_o <= 1'b0;   // one cycle pulse.
            if (reg_wr_i) begin
                case (reg_addr_i)
                    ADDR_CONTROL: begin
                        soft_rst_o <= reg_wdata_i[0];
                        cpol_o     <= reg_wdata_i[1];
                        cpha_o     <= reg_wdata_i[2];
                    end
                    ADDR_CLK_DIV:   clk_div_o   <= reg_wdata_i[$bits(clk_div_t)-1:0];
                    ADDR_WAIT_TIME: wait_time_o <= reg_wdata_i[$bits(wait_time_t)-1:0];
                    ADDR_SLAVE_SEL: slave_sel_o <= reg_wdata_i[$clog2(SLAVE_NUM)-1:0];
                    default: ;
                endcase
            end
        end
    end

    // read path ------------
    always_comb begin
        case (reg_addr_i)
            ADDR_CONTROL:   rd_mux = reg_data_t'({cpha_o, cpol_o, soft_rst_o});
            ADDR_STATUS:    rd_mux = status_word;
            ADDR_CLK_DIV:   rd_mux = reg_data_t'(clk_div_o);
            ADDR_WAIT_TIME: rd_mux = reg_data_t'(wait_time_o);
            ADDR_SLAVE_SEL: rd_mux = reg_data_t'(slave_sel_o);
            ADDR_RX_DATA:   rd_mux = rx_valid_i ? reg_data_t'(rx_byte_i) : '0;
            ADDR_PARAM:     rd_mux = param_word;
            default:        rd_mux = '0;   // tx data is write only.
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            reg_rdata_o <= '0;
        end else if (reg_rd_i) begin
            reg_rdata_o <= rd_mux;
        end
    end

    // the flush from a soft reset would swallow a word written right behind it.
    a_no_push_on_flush: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        soft_rst_o |-> !tx_push_o)
        else $error("tx push issued during soft reset");

endmodule

/* verilog/spi_engine.sv */
/*
 * SPI shift engine.
 * Takes words from the TX FIFO, shifts them out MSB first on MOSI while
 * sampling MISO, and pushes each received byte into the RX FIFO.
 * cpol/cpha pick the idle level and edges, clk_div the SCLK half period.
 * A word with the last flag closes the frame and starts the wait time.
 */
`timescale 1ns/1ns

module spi_engine (
    input  logic                                  clk_i,
    input  logic                                  rst_n_i,
    input  logic                                  soft_rst_i,
    input  logic                                  cpol_i,
    input  logic                                  cpha_i,
    input  spi_pkg::clk_div_t                     clk_div_i,
    input  spi_pkg::wait_time_t                   wait_time_i,
    input  logic [$clog2(spi_pkg::SLAVE_NUM)-1:0] slave_sel_i,
    input  logic                                  tx_valid_i,
    input  spi_pkg::spi_tx_word_t                 tx_word_i,
    input  logic                                  rx_ready_i,
    input  logic                                  miso_i,
    output logic                                  tx_pop_o,
    output logic                                  rx_push_o,
    output spi_pkg::spi_data_t                    rx_byte_o,
    output logic                                  busy_o,
    output logic                                  sclk_o,
    output logic                                  mosi_o,
    output logic [spi_pkg::SLAVE_NUM-1:0]         cs_n_o
);
    import spi_pkg::*;

    engine_state_t state;
    clk_div_t      half_cnt;
    wait_time_t    gap_cnt;
    logic [3:0]    edge_cnt;     // 16 sclk edges per word.
    spi_data_t     tx_sr;
    spi_data_t     rx_sr;
    logic          last_q;
    logic          rx_pend;
    logic          half_done;
    logic          sample_edge;
    logic          rx_done;

    assign half_done   = (half_cnt == '0);
    assign sample_edge = ~edge_cnt[0] ^ cpha_i;   // leading edge for cpha 0.
    assign rx_done     = ~rx_pend | rx_ready_i;

    assign tx_pop_o  = (state == LOAD) && tx_valid_i;
    assign rx_push_o = (state == HOLD) && rx_pend && rx_ready_i;
    assign rx_byte_o = rx_sr;
    assign busy_o    = (state != IDLE);

    // state and pins -------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || soft_rst_i) begin
            state   <= IDLE;
            sclk_o  <= cpol_i & rst_n_i;   // back to idle level.
            mosi_o  <= 1'b0;
            cs_n_o  <= '1;
            rx_pend <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    sclk_o <= cpol_i;
                    if (tx_valid_i) begin
                        state <= LOAD;
                    end
                end
                LOAD: begin
                    // cs stays low here while the frame is open.
                    if (tx_valid_i) begin
                        cs_n_o              <= '1;
                        cs_n_o[slave_sel_i] <= 1'b0;
                        if (!cpha_i) begin
                            mosi_o <= tx_word_i[SPI_DATA_WIDTH-1];   // first bit before edge.
                        end
                        state <= SHIFT;
                    end
                end
                SHIFT: begin
                    if (half_done) begin
                        sclk_o <= ~sclk_o;
                        if (!sample_edge) begin
                            mosi_o <= tx_sr[SPI_DATA_WIDTH-1];
                        end
                        if (edge_cnt == 4'd15) begin
                            rx_pend <= 1'b1;
                            state   <= HOLD;
                        end
                    end
                end
                HOLD: begin
                    if (rx_push_o) begin
                        rx_pend <= 1'b0;
                    end
                    if (rx_done && !last_q) begin
                        state <= LOAD;
                    end else if (rx_done && half_done) begin
                        cs_n_o <= '1;   // frame closed.
                        state  <= GAP;
                    end
                end
                GAP: begin
                    if (gap_cnt == '0) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // counters and shifters.
    always_ff @(posedge clk_i) begin
        case (state)
            LOAD: begin
                half_cnt <= clk_div_i;
                edge_cnt <= '0;
                last_q   <= tx_word_i[SPI_DATA_WIDTH];
                tx_sr    <= cpha_i ? tx_word_i[SPI_DATA_WIDTH-1:0]
                                   : {tx_word_i[SPI_DATA_WIDTH-2:0], 1'b0};
            end
            SHIFT: begin
                if (half_done) begin
                    half_cnt <= clk_div_i;
                    edge_cnt <= edge_cnt + 1'b1;
                    if (sample_edge) begin
                        rx_sr <= {rx_sr[SPI_DATA_WIDTH-2:0], miso_i};
                    end else begin
                        tx_sr <= {tx_sr[SPI_DATA_WIDTH-2:0], 1'b0};
                    end
                end else begin
                    half_cnt <= half_cnt - 1'b1;
                end
            end
            HOLD: begin
                gap_cnt <= wait_time_i;
                if (!half_done) begin
                    half_cnt <= half_cnt - 1'b1;
                end
            end
            GAP: begin
                if (gap_cnt != '0) begin
                    gap_cnt <= gap_cnt - 1'b1;
                end
            end
            default: ;
        endcase
    end

    a_one_cs: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(~cs_n_o))
        else $error("more than one chip select active");

endmodule

/* verilog/spi_ctrl.sv */
/*
 * Top level of the SPI master controller.
 * Connects the register port, the TX and RX FIFOs and the shift engine.
 * All blocks share one clock and one synchronous reset.
 */
`timescale 1ns/1ns

module spi_ctrl (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  spi_pkg::reg_addr_t            reg_addr_i,
    input  logic                          reg_wr_i,
    input  spi_pkg::reg_data_t            reg_wdata_i,
    input  logic                          reg_rd_i,
    output spi_pkg::reg_data_t            reg_rdata_o,
    output logic                          sclk_o,
    output logic                          mosi_o,
    input  logic                          miso_i,
    output logic [spi_pkg::SLAVE_NUM-1:0] cs_n_o
);
    import spi_pkg::*;

    logic                         tx_push;
    spi_tx_word_t                 tx_word;
    logic                         tx_ready;
    logic                         tx_valid;
    spi_tx_word_t                 tx_word_out;
    logic                         tx_pop;
    logic                         rx_push;
    spi_data_t                    rx_byte;
    logic                         rx_ready;
    logic                         rx_valid;
    spi_data_t                    rx_byte_out;
    logic                         rx_pop;
    logic                         cpol;
    logic                         cpha;
    clk_div_t                     clk_div;
    wait_time_t                   wait_time;
    logic [$clog2(SLAVE_NUM)-1:0] slave_sel;
    logic                         soft_rst;
    logic                         busy;

    spi_reg_file reg_file (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .reg_addr_i (reg_addr_i),
        .reg_wr_i   (reg_wr_i),
        .reg_wdata_i(reg_wdata_i),
        .reg_rd_i   (reg_rd_i),
        .tx_ready_i (tx_ready),
        .tx_empty_i (~tx_valid),
        .rx_valid_i (rx_valid),
        .rx_full_i  (~rx_ready),
        .rx_byte_i  (rx_byte_out),
        .busy_i     (busy),
        .reg_rdata_o(reg_rdata_o),
        .tx_push_o  (tx_push),
        .tx_word_o  (tx_word),
        .rx_pop_o   (rx_pop),
        .cpol_o     (cpol),
        .cpha_o     (cpha),
        .clk_div_o  (clk_div),
        .wait_time_o(wait_time),
        .slave_sel_o(slave_sel),
        .soft_rst_o (soft_rst)
    );

    spi_fifo #(
        .WIDTH(SPI_DATA_WIDTH + 1),
        .DEPTH(FIFO_DEPTH)
    ) tx_fifo (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .flush_i    (soft_rst),
        .in_valid_i (tx_push),
        .in_data_i  (tx_word),
        .in_ready_o (tx_ready),
        .out_valid_o(tx_valid),
        .out_data_o (tx_word_out),
        .out_ready_i(tx_pop)
    );

    spi_fifo #(
        .WIDTH(SPI_DATA_WIDTH),
        .DEPTH(FIFO_DEPTH)
    ) rx_fifo (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .flush_i    (soft_rst),
        .in_valid_i (rx_push),
        .in_data_i  (rx_byte),
        .in_ready_o (rx_ready),
        .out_valid_o(rx_valid),
        .out_data_o (rx_byte_out),
        .out_ready_i(rx_pop)
    );

    spi_engine engine (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .soft_rst_i (soft_rst),
        .cpol_i     (cpol),
        .cpha_i     (cpha),
        .clk_div_i  (clk_div),
        .wait_time_i(wait_time),
        .slave_sel_i(slave_sel),
        .tx_valid_i (tx_valid),
        .tx_word_i  (tx_word_out),
        .rx_ready_i (rx_ready),
        .miso_i     (miso_i),
        .tx_pop_o   (tx_pop),
        .rx_push_o  (rx_push),
        .rx_byte_o  (rx_byte),
        .busy_o     (busy),
        .sclk_o     (sclk_o),
        .mosi_o     (mosi_o),
        .cs_n_o     (cs_n_o)
    );

endmodule

/* testbench/spi_slave_model.sv */
/*
 * Behavioural SPI slave for the controller testbench.
 * Samples MOSI on the sample edge of the given mode while its chip select
 * is low, keeps every byte in a queue and counts frames on chip select
 * rising edges. MISO echoes the inverted MOSI bit.
 */
`timescale 1ns/1ns

module spi_slave_model (
    input  logic cpol_i,
    input  logic cpha_i,
    input  logic sclk_i,
    input  logic mosi_i,
    input  logic cs_n_i,
    output logic miso_o
);
    logic [7:0] byte_q [$];   // captured mosi bytes.
    int         frame_cnt = 0;
    int         bit_cnt   = 0;
    logic [6:0] shift_sr  = '0;
    logic       sclk_q    = 1'b0;
    logic       cs_n_q    = 1'b1;

    assign miso_o = ~mosi_i;

    // sample edge is rising when cpol equals cpha.
    always @(posedge sclk_i or negedge sclk_i or posedge cs_n_i or negedge cs_n_i) begin
        if (cs_n_i) begin
            if (!cs_n_q) begin
                frame_cnt = frame_cnt + 1;
            end
            bit_cnt = 0;   // drop a partial byte.
        end else if (sclk_i != sclk_q && sclk_i == (cpol_i == cpha_i)) begin
            if (bit_cnt == 7) begin
                byte_q.push_back({shift_sr, mosi_i});
                bit_cnt = 0;
            end else begin
                shift_sr = {shift_sr[5:0], mosi_i};
                bit_cnt  = bit_cnt + 1;
            end
        end
        sclk_q = sclk_i;
        cs_n_q = cs_n_i;
    end

endmodule

/* testbench/spi_ctrl_tb.sv */
/*
 * Directed testbench for the SPI master controller.
 * Drives the register port on the falling clock edge, talks to a
 * behavioural slave on chip select 1 and checks reset values, all four
 * SPI modes, a multi-word frame, FIFO overflow with back-pressure and
 * the soft reset. One line per test, then a closing summary.
 */
`timescale 1ns/1ns

module spi_ctrl_tb;
    import spi_pkg::*;

    // slowest case is 17 frames at half period 256, plus the soft reset test.
    localparam int SLOW_HALF      = 256;
    localparam int SLOW_FRAME     = 17 * SLOW_HALF + 16;
    localparam int TIMEOUT_CYCLES = 20 * SLOW_FRAME + 4000;

    logic        clk;
    logic        rst_n;
    reg_addr_t   reg_addr;
    logic        reg_wr;
    logic [31:0] reg_wdata;
    logic        reg_rd;
    logic [31:0] reg_rdata;
    logic        sclk;
    logic        mosi;
    logic        miso;
    logic [1:0]  cs_n;
    logic        model_cpol;
    logic        model_cpha;
    logic [31:0] rng_state = 32'hc33f;
    int          error_cnt = 0;
    int          test_cnt  = 0;
    int          cycle_cnt = 0;
    int          cs0_falls = 0;
    int          cs1_falls = 0;

    spi_ctrl spi_ctrl_inst (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .reg_addr_i (reg_addr),
        .reg_wr_i   (reg_wr),
        .reg_wdata_i(reg_wdata),
        .reg_rd_i   (reg_rd),
        .reg_rdata_o(reg_rdata),
        .sclk_o     (sclk),
        .mosi_o     (mosi),
        .miso_i     (miso),
        .cs_n_o     (cs_n)
    );

    spi_slave_model slave (
        .cpol_i(model_cpol),
        .cpha_i(model_cpha),
        .sclk_i(sclk),
        .mosi_i(mosi),
        .cs_n_i(cs_n[1]),
        .miso_o(miso)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(negedge cs_n[0]) cs0_falls <= cs0_falls + 1;
    always @(negedge cs_n[1]) cs1_falls <= cs1_falls + 1;

    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run stopped after %0d cycles", cycle_cnt);
        $display("*** FAILED ***");
        $finish;
    end

    // helpers --------------------
    function automatic logic [7:0] random_byte();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state[7:0];
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        error_cnt++;
    endtask

    task automatic report_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        error_cnt++;
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_cnt++;
        if (error_cnt == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, error_cnt - errs_before);
        end
    endtask

    task automatic reg_write(input reg_addr_t addr, input logic [31:0] data);
        @(negedge clk);
        reg_addr  = addr;
        reg_wdata = data;
        reg_wr    = 1'b1;
        @(negedge clk);
        reg_wr = 1'b0;
    endtask

    task automatic reg_read(input reg_addr_t addr, output logic [31:0] data);
        @(negedge clk);
        reg_addr = addr;
        reg_rd   = 1'b1;
        @(negedge clk);
        reg_rd = 1'b0;
        data   = reg_rdata;   // registered one cycle after the strobe.
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        do begin
            reg_read(ADDR_STATUS, st);
        end while (st[4] || !st[1]);
    endtask

    task automatic wait_rx_data();
        logic [31:0] st;
        do begin
            reg_read(ADDR_STATUS, st);
        end while (st[0]);
    endtask

    // tests ----------------------
    task automatic check_reset_values();
        logic [31:0] rd;
        int          errs;
        errs = error_cnt;
        reg_read(ADDR_CONTROL, rd);
        if (rd !== 32'd0) report_mismatch("control", rd, 32'd0);
        reg_read(ADDR_CLK_DIV, rd);
        if (rd !== 32'd1) report_mismatch("clk_div", rd, 32'd1);
        reg_read(ADDR_WAIT_TIME, rd);
        if (rd !== 32'd2) report_mismatch("wait_time", rd, 32'd2);
        reg_read(ADDR_STATUS, rd);
        if (rd[4:0] !== 5'b00011) report_mismatch("status", 32'(rd[4:0]), 32'h3);
        reg_read(ADDR_PARAM, rd);
        if (rd[15:0] !== 16'h1008) report_mismatch("param", 32'(rd[15:0]), 32'h1008);
        if (cs_n !== 2'b11) report_mismatch("cs_n_o", 32'(cs_n), 32'h3);
        end_test("reset_values", errs);
    endtask

    task automatic run_spi_modes();
        logic [7:0]  data;
        logic [31:0] rd;
        int          base;
        int          cs0;
        int          cs1;
        int          errs;
        errs = error_cnt;
        reg_write(ADDR_SLAVE_SEL, 32'd1);
        for (int m = 0; m < 4; m++) begin
            model_cpol = m[1];
            model_cpha = m[0];
            reg_write(ADDR_CONTROL, {29'd0, model_cpha, model_cpol, 1'b0});
            data = random_byte();
            base = slave.byte_q.size();
            cs0  = cs0_falls;
            cs1  = cs1_falls;
            reg_write(ADDR_TX_DATA, {23'd0, 1'b1, data});
            wait_idle();
            if (slave.byte_q.size() != base + 1) begin
                report_error("slave did not capture exactly one byte");
            end else if (slave.byte_q[base] !== data) begin
                report_mismatch("slave byte", 32'(slave.byte_q[base]), 32'(data));
            end
            if (cs0_falls != cs0) report_error("cs_n_o[0] went low for slave 1");
            if (cs1_falls != cs1 + 1) report_mismatch("cs_n_o[1] falls", 32'(cs1_falls - cs1), 1);
            reg_read(ADDR_RX_DATA, rd);
            if (rd !== {24'd0, ~data}) report_mismatch("rx data", rd, {24'd0, ~data});
            if (sclk !== model_cpol) report_mismatch("sclk_o", 32'(sclk), 32'(model_cpol));
        end
        end_test("spi_modes", errs);
    endtask

    task automatic send_multi_word_frame();
        logic [7:0]  sent [5];
        logic [31:0] rd;
        int          base;
        int          frames;
        int          errs;
        errs = error_cnt;
        model_cpol = 1'b0;
        model_cpha = 1'b0;
        reg_write(ADDR_CONTROL, 32'd0);
        reg_write(ADDR_CLK_DIV, 32'd3);
        base   = slave.byte_q.size();
        frames = slave.frame_cnt;
        for (int i = 0; i < 5; i++) begin
            sent[i] = random_byte();
            reg_write(ADDR_TX_DATA, {23'd0, (i == 4), sent[i]});   // last on the fifth.
        end
        wait_idle();
        if (slave.frame_cnt != frames + 1) report_mismatch("frames", 32'(slave.frame_cnt - frames), 1);
        if (slave.byte_q.size() != base + 5) begin
            report_error("slave byte count wrong for the five-word frame");
        end else begin
            for (int i = 0; i < 5; i++) begin
                if (slave.byte_q[base + i] !== sent[i]) begin
                    report_mismatch("slave byte", 32'(slave.byte_q[base + i]), 32'(sent[i]));
                end
            end
        end
        for (int i = 0; i < 5; i++) begin
            reg_read(ADDR_RX_DATA, rd);
            if (rd !== {24'd0, ~sent[i]}) report_mismatch("rx data", rd, {24'd0, ~sent[i]});
        end
        end_test("multi_word_frame", errs);
    endtask

    task automatic fill_fifos();
        logic [7:0]  sent [17];
        logic [31:0] st;
        logic [31:0] rd;
        int          base;
        int          errs;
        errs = error_cnt;
        base = slave.byte_q.size();
        reg_write(ADDR_CLK_DIV, 32'd255);
        for (int i = 0; i < 17; i++) begin
            sent[i] = random_byte();
            reg_write(ADDR_TX_DATA, {23'd0, 1'b1, sent[i]});
        end
        // one word is already in the engine, so 16 fill the TX FIFO.
        reg_read(ADDR_STATUS, st);
        if (!st[3]) report_error("tx_full not set with the TX FIFO filled");
        reg_write(ADDR_TX_DATA, {23'd0, 1'b1, 8'h5a});
        do begin
            reg_read(ADDR_STATUS, st);
        end while (slave.byte_q.size() < base + 17);
        repeat (2 * SLOW_HALF) @(negedge clk);   // engine parks in HOLD.
        reg_read(ADDR_STATUS, st);
        if (st[4:0] !== 5'b10110) report_mismatch("status", 32'(st[4:0]), 32'h16);
        for (int i = 0; i < 17; i++) begin
            wait_rx_data();
            reg_read(ADDR_RX_DATA, rd);
            if (rd !== {24'd0, ~sent[i]}) report_mismatch("rx data", rd, {24'd0, ~sent[i]});
        end
        wait_idle();
        if (slave.byte_q.size() != base + 17) report_error("dropped word reached the slave");
        for (int i = 0; i < 17; i++) begin
            if (slave.byte_q[base + i] !== sent[i]) begin
                report_mismatch("slave byte", 32'(slave.byte_q[base + i]), 32'(sent[i]));
            end
        end
        end_test("fifo_full_backpressure", errs);
    endtask

    task automatic apply_soft_reset();
        logic [7:0]  data;
        logic [31:0] rd;
        int          base;
        int          errs;
        errs = error_cnt;
        model_cpol = 1'b1;
        model_cpha = 1'b1;
        reg_write(ADDR_CONTROL, 32'h6);
        reg_write(ADDR_WAIT_TIME, 32'd5);
        for (int i = 0; i < 4; i++) begin
            reg_write(ADDR_TX_DATA, {23'd0, (i == 3), random_byte()});
        end
        do begin
            reg_read(ADDR_STATUS, rd);
        end while (cs_n[1]);
        reg_write(ADDR_CONTROL, 32'h7);   // reset bit with mode 3 kept.
        reg_read(ADDR_STATUS, rd);
        if (rd[4:0] !== 5'b00011) report_mismatch("status", 32'(rd[4:0]), 32'h3);
        if (cs_n !== 2'b11) report_mismatch("cs_n_o", 32'(cs_n), 32'h3);
        if (sclk !== 1'b1) report_mismatch("sclk_o", 32'(sclk), 32'h1);
        reg_read(ADDR_CONTROL, rd);
        if (rd !== 32'h6) report_mismatch("control", rd, 32'h6);
        reg_read(ADDR_CLK_DIV, rd);
        if (rd !== 32'd255) report_mismatch("clk_div", rd, 32'd255);
        reg_read(ADDR_WAIT_TIME, rd);
        if (rd !== 32'd5) report_mismatch("wait_time", rd, 32'd5);
        reg_read(ADDR_SLAVE_SEL, rd);
        if (rd !== 32'd1) report_mismatch("slave_sel", rd, 32'd1);
        reg_write(ADDR_CLK_DIV, 32'd2);
        data = random_byte();
        base = slave.byte_q.size();
        reg_write(ADDR_TX_DATA, {23'd0, 1'b1, data});
        wait_idle();
        if (slave.byte_q.size() != base + 1) begin
            report_error("no byte captured after soft reset");
        end else if (slave.byte_q[base] !== data) begin
            report_mismatch("slave byte", 32'(slave.byte_q[base]), 32'(data));
        end
        reg_read(ADDR_RX_DATA, rd);
        if (rd !== {24'd0, ~data}) report_mismatch("rx data", rd, {24'd0, ~data});
        end_test("soft_reset", errs);
    endtask

    // main sequence --------------
    initial begin
        rst_n      = 1'b0;
        reg_addr   = '0;
        reg_wr     = 1'b0;
        reg_wdata  = '0;
        reg_rd     = 1'b0;
        model_cpol = 1'b0;
        model_cpha = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_reset_values();
        run_spi_modes();
        send_multi_word_frame();
        fill_fifos();
        apply_soft_reset();

        $display("%0d tests run, %0d checks failed", test_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* flist.f */
verilog/spi_pkg.sv
verilog/spi_fifo.sv
verilog/spi_reg_file.sv
verilog/spi_engine.sv
verilog/spi_ctrl.sv
testbench/spi_slave_model.sv
testbench/spi_ctrl_tb.sv

/* Makefile */
# Verilator build and run for the SPI master controller testbench.

VERILATOR ?= verilator
TOP       ?= spi_ctrl_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

SRCS := $(shell cat $(FLIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qxF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
